/* filelist.f */
hdl/cachePkg.sv
hdl/cacheCtrlIf.sv
hdl/cacheFsm.sv
hdl/cacheTagArray.sv
hdl/cacheDataArray.sv
hdl/dataCache.sv
bench/dataCache_assert.sv
bench/dataCacheTb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f filelist.f --top-module dataCacheTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/VdataCacheTb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

/* bench/dataCacheTb.sv */
// data cache testbench
`default_nettype none

module dataCacheTb
  import cachePkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic reset, flushCache, cpuBusy, busAck;
  logic [1:0] cacheRW, busRW;
  logic [31:0] cpuAdr, cpuWriteData, readData, busAdr;
  logic [127:0] busReadLine, busWriteLine;
  logic cacheStall, cacheCommitted, cacheAccess, cacheMiss;

  // memory side and reference model state
  logic [127:0] busMem [64];
  logic [127:0] refMem [64];
  logic [7:0] lfsr;
  int busReads, busWrites, accessCnt, missCnt, errCnt, checkCnt;
  logic [31:0] wbAdr[$], expAdr[$];
  logic [127:0] wbLine[$], expLine[$];
  // bus transfers in acknowledge order
  cacheRwT busLog[$];
  logic mValid [8][2];
  logic mDirty [8][2];
  logic [26:0] mTag [8][2];
  logic [127:0] mLine [8][2];
  logic mLru [8];
  // stimulus table with op codes 0 read, 1 write and 2 flush
  int tOp[$];
  logic [31:0] tAdr[$], tData[$];
  logic tBusy[$];

  dataCache i_dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [7:0] lfsrStep(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("test failed");
    $finish;
  endtask

  task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkRw(input string what, input cacheRwT got, input cacheRwT exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkLine(input string what, input logic [127:0] got, input logic [127:0] exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic addRow(input int op, input logic [31:0] adr, input logic [31:0] wd, input logic b);
    tOp.push_back(op);
    tAdr.push_back(adr);
    tData.push_back(wd);
    tBusy.push_back(b);
  endtask

  //////////////////////////////////////////////////
  // reference cache model
  //////////////////////////////////////////////////

  task automatic writeBackModel(input int s, input int w);
    logic [31:0] a;
    a = {mTag[s][w], 3'(s), 2'b00};
    expAdr.push_back(a);
    expLine.push_back(mLine[s][w]);
    refMem[a[7:2]] = mLine[s][w];
    mDirty[s][w] = 1'b0;
  endtask

  task automatic modelAccess(input int op, input logic [31:0] adr, input logic [31:0] wd,
                             output logic [31:0] expRead, output int expMiss);
    int s, w, hw, v;
    logic [127:0] ln;
    s = int'(adr[4:2]);
    w = int'(adr[1:0]);
    hw = -1;
    for (int i = 0; i < 2; i++) begin
      if (mValid[s][i] && mTag[s][i] == adr[31:5]) hw = i;
    end
    if (hw >= 0) begin
      expMiss = 0;
      v = hw;
      if (op == 1) begin
        mLine[s][v][w*32 +: 32] = wd;
        mDirty[s][v] = 1'b1;
      end
    end else begin
      expMiss = 1;
      // first invalid way, else least recently used
      if (!mValid[s][0]) v = 0;
      else if (!mValid[s][1]) v = 1;
      else if (mLru[s]) v = 1;
      else v = 0;
      if (mValid[s][v] && mDirty[s][v]) writeBackModel(s, v);
      ln = refMem[adr[7:2]];
      if (op == 1) ln[w*32 +: 32] = wd;
      mLine[s][v] = ln;
      mValid[s][v] = 1'b1;
      mTag[s][v] = adr[31:5];
      mDirty[s][v] = (op == 1);
    end
    mLru[s] = (v == 0);
    expRead = mLine[s][v][w*32 +: 32];
  endtask

  //////////////////////////////////////////////////
  // memory model with a random acknowledge delay
  //////////////////////////////////////////////////

  initial begin
    int d;
    logic [1:0] rw;
    logic [31:0] adr;
    logic [127:0] ln;
    busAck = 1'b0;
    busReadLine = '0;
    lfsr = 8'd98;
    for (int l = 0; l < 64; l++) begin
      for (int i = 0; i < 4; i++) busMem[l][i*32 +: 32] = 32'(l * 4 + i);
    end
    forever begin
      @(negedge clk);
      if (!reset && busRW != 2'b00) begin
        lfsr = lfsrStep(lfsr);
        d = int'(lfsr[0]);
        lfsr = lfsrStep(lfsr);
        d = 1 + 2 * d + int'(lfsr[0]);
        repeat (d - 1) @(negedge clk);
        rw = busRW;
        adr = busAdr;
        ln = busWriteLine;
        @(posedge clk);
        #1;
        busLog.push_back(rw);
        if (rw[0]) begin
          busMem[adr[7:2]] = ln;
          busWrites++;
          wbAdr.push_back(adr);
          wbLine.push_back(ln);
        end else begin
          busReadLine = busMem[adr[7:2]];
          busReads++;
        end
        busAck = 1'b1;
        @(posedge clk);
        #1 busAck = 1'b0;
      end
    end
  end

  // performance pulses
  always @(negedge clk) begin
    if (!reset && cacheAccess) accessCnt++;
    if (!reset && cacheMiss) missCnt++;
  end

  //////////////////////////////////////////////////
  // one table row
  //////////////////////////////////////////////////

  task automatic runRow(input int r);
    int cyc, expMiss, m0, rd0, e0;
    logic [31:0] expRead, gotRead;
    m0 = missCnt;
    rd0 = busReads;
    e0 = errCnt;
    expRead = '0;
    expMiss = 0;
    if (tOp[r] == 2) begin
      for (int s = 0; s < 8; s++) begin
        for (int w = 0; w < 2; w++) begin
          if (mValid[s][w] && mDirty[s][w]) writeBackModel(s, w);
        end
      end
    end else begin
      modelAccess(tOp[r], tAdr[r], tData[r], expRead, expMiss);
    end
    @(posedge clk);
    #1;
    if (tOp[r] == 2) flushCache = 1'b1;
    else cacheRW = (tOp[r] == 0) ? 2'b10 : 2'b01;
    cpuAdr = tAdr[r];
    cpuWriteData = tData[r];
    cpuBusy = tBusy[r];
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
      if (cyc > 500) abortRun("timeout waiting for cacheStall to fall");
    end while (cacheStall);
    gotRead = readData;
    if (tBusy[r]) begin
      // controller waits in its delay cycle while the CPU is busy
      repeat (3) begin
        @(posedge clk);
        #1 cacheRW = 2'b00;
        @(negedge clk);
        checkWord("stall while busy", {31'b0, cacheStall}, 32'd0);
        checkWord("committed while busy", {31'b0, cacheCommitted}, 32'd1);
      end
      @(posedge clk);
      #1 cpuBusy = 1'b0;
      cyc = 0;
      do begin
        @(negedge clk);
        cyc++;
        if (cyc > 50) abortRun("timeout waiting for cacheCommitted to fall");
      end while (cacheCommitted);
    end
    @(posedge clk);
    #1;
    cacheRW = 2'b00;
    flushCache = 1'b0;
    cpuBusy = 1'b0;
    #1;
    checkRw("bus idle after row", busRW, 2'b00);
    if (tOp[r] == 0) checkWord("read data", gotRead, expRead);
    checkWord("miss pulses", 32'(missCnt - m0), 32'(expMiss));
    checkWord("line fetches", 32'(busReads - rd0), 32'(expMiss));
    checkWord("write-back count", 32'(wbAdr.size()), 32'(expAdr.size()));
    for (int k = 0; k < wbAdr.size() && k < expAdr.size(); k++) begin
      checkWord("write-back address", wbAdr[k], expAdr[k]);
      checkLine("write-back line", wbLine[k], expLine[k]);
    end
    // write-backs come first, the fetch follows them
    for (int k = 0; k < busLog.size(); k++) begin
      checkRw("bus transfer order", busLog[k], (k < expAdr.size()) ? 2'b01 : 2'b10);
    end
    busLog.delete();
    wbAdr.delete();
    wbLine.delete();
    expAdr.delete();
    expLine.delete();
    if (tOp[r] == 2) begin
      for (int l = 0; l < 64; l++) checkLine("memory after flush", busMem[l], refMem[l]);
    end
    $display("row %0d op %0d adr %h: %s", r, tOp[r], tAdr[r], (errCnt == e0) ? "ok" : "errors");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int nReq;
    reset = 1'b1;
    flushCache = 1'b0;
    cpuBusy = 1'b0;
    cacheRW = 2'b00;
    cpuAdr = '0;
    cpuWriteData = '0;
    nReq = 0;
    for (int l = 0; l < 64; l++) begin
      for (int i = 0; i < 4; i++) refMem[l][i*32 +: 32] = 32'(l * 4 + i);
    end
    for (int s = 0; s < 8; s++) begin
      mLru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        mValid[s][w] = 1'b0;
        mDirty[s][w] = 1'b0;
      end
    end
    // clean miss, hits, write then read back
    addRow(0, 32'h04, 32'h0, 1'b0);
    addRow(0, 32'h05, 32'h0, 1'b0);
    addRow(1, 32'h06, 32'ha5a50001, 1'b0);
    addRow(0, 32'h06, 32'h0, 1'b0);
    // write miss merge, read all four words
    addRow(1, 32'h24, 32'h5a5a0002, 1'b0);
    addRow(0, 32'h25, 32'h0, 1'b0);
    addRow(0, 32'h26, 32'h0, 1'b0);
    addRow(0, 32'h27, 32'h0, 1'b0);
    addRow(0, 32'h24, 32'h0, 1'b0);
    // dirty LRU victim evicted
    addRow(0, 32'h44, 32'h0, 1'b0);
    addRow(1, 32'h10, 32'h11110003, 1'b0);
    addRow(1, 32'h30, 32'h22220004, 1'b0);
    addRow(0, 32'h50, 32'h0, 1'b0);
    // miss with a busy CPU
    addRow(0, 32'h0c, 32'h0, 1'b1);
    addRow(1, 32'h2c, 32'h33330005, 1'b0);
    addRow(2, 32'h0, 32'h0, 1'b0);
    // flushed lines still hit
    addRow(0, 32'h24, 32'h0, 1'b0);
    addRow(0, 32'h30, 32'h0, 1'b0);
    addRow(0, 32'h2c, 32'h0, 1'b0);
    addRow(0, 32'h44, 32'h0, 1'b0);
    addRow(1, 32'h51, 32'h44440006, 1'b0);
    addRow(0, 32'h31, 32'h0, 1'b0);
    // busy CPU on an evicting miss
    addRow(0, 32'h72, 32'h0, 1'b1);
    addRow(1, 32'h73, 32'h55550007, 1'b0);
    addRow(2, 32'h0, 32'h0, 1'b0);
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    for (int r = 0; r < tOp.size(); r++) begin
      if (tOp[r] != 2) nReq++;
      runRow(r);
    end
    checkWord("access pulses total", 32'(accessCnt), 32'(nReq));
    $display("%0d rows, %0d checks, %0d errors", tOp.size(), checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // overall limit on run time
  initial begin
    #2000000;
    abortRun("simulation watchdog expired");
  end

endmodule

`default_nettype wire

/* bench/dataCache_assert.sv */
// controller bus checks
`default_nettype none

module dataCacheAssert
  import cachePkg::*;
(
  input logic       clk,
  input logic       reset,
  input cacheRwT    busRW,
  input logic       busAck,
  input logic       cacheStall,
  input logic       cacheCommitted,
  input logic [3:0] state
);
  timeunit 1ns;
  timeprecision 1ps;

  // read and write never requested together
  assert property (@(posedge clk) disable iff (reset) busRW != 2'b11)
    else $error("busRW carries read and write at once");

  // a ready controller without a stall stays uncommitted in the next cycle
  assert property (@(posedge clk) disable iff (reset)
    (state == stReady && !cacheStall) |=> !cacheCommitted)
    else $error("cacheCommitted rose after a ready cycle without stall");

  // request level held until the acknowledge cycle
  assert property (@(posedge clk) disable iff (reset)
    (busRW != 2'b00 && !busAck) |=> (busAck || busRW == $past(busRW)))
    else $error("busRW changed before busAck");

endmodule

bind cacheFsm dataCacheAssert fsmChecks (
  .clk, .reset, .busRW, .busAck, .cacheStall, .cacheCommitted, .state
);

`default_nettype wire

/* hdl/dataCache.sv */
// data cache top level
`default_nettype none

module dataCache
  import cachePkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         flushCache,
  input  logic         cpuBusy,
  input  logic         busAck,
  input  logic [1:0]   cacheRW,
  input  logic [31:0]  cpuAdr,
  input  logic [31:0]  cpuWriteData,
  input  logic [127:0] busReadLine,
  output logic [31:0]  readData,
  output logic         cacheStall,
  output logic         cacheCommitted,
  output logic         cacheAccess,
  output logic         cacheMiss,
  output logic [1:0]   busRW,
  output logic [31:0]  busAdr,
  output logic [127:0] busWriteLine
);

  cacheCtrlIf ctrlBus ();

  cacheAdrT           cpuAdrU;
  cacheAdrT           busAdrU;
  logic [setBits-1:0] flushSet;

  assign cpuAdrU = cpuAdr;

  cacheFsm fsm (
    .clk, .reset, .cacheRW, .flushCache, .cpuBusy, .busAck,
    .ctrl(ctrlBus.fsm),
    .cacheStall, .cacheCommitted, .cacheAccess, .cacheMiss, .busRW
  );

  cacheTagArray tagArray (
    .clk, .reset, .cpuAdr(cpuAdrU), .cacheRW,
    .ctrl(ctrlBus.tags),
    .flushSet
  );

  cacheDataArray dataArray (
    .clk, .cpuAdr(cpuAdrU), .cpuWriteData, .busReadLine, .cacheRW,
    .ctrl(ctrlBus.data),
    .flushSet, .readData,
    .victimLine(busWriteLine)
  );

  // line address, victim for a write-back, CPU line for a fetch
  always_comb begin
    busAdrU.bus.word = '0;
    if (ctrlBus.selFlush) busAdrU.bus.line = {ctrlBus.victimTag, flushSet};
    else if (ctrlBus.selEvict) busAdrU.bus.line = {ctrlBus.victimTag, cpuAdrU.lookup.set};
    else busAdrU.bus.line = cpuAdrU.bus.line;
  end

  assign busAdr = busAdrU;

endmodule

`default_nettype wire

/* hdl/cacheDataArray.sv */
// cache data array
`default_nettype none

module cacheDataArray
  import cachePkg::*;
(
  input  logic                clk,
  input  cacheAdrT            cpuAdr,
  input  logic [31:0]         cpuWriteData,
  input  logic [lineBits-1:0] busReadLine,
  input  cacheRwT             cacheRW,
  cacheCtrlIf.data            ctrl,
  input  logic [setBits-1:0]  flushSet,
  output logic [31:0]         readData,
  output logic [lineBits-1:0] victimLine
);

  logic [lineBits-1:0] lineMem [numSets][numWays];
  logic [lineBits-1:0] busBuffer;
  logic [lineBits-1:0] fillLine;
  logic [lineBits-1:0] hitLine;
  logic [setBits-1:0]  cpuSet;
  logic [setBits-1:0]  victimSet;
  logic [wordBits-1:0] cpuWord;

  assign cpuSet    = cpuAdr.lookup.set;
  assign cpuWord   = cpuAdr.lookup.word;
  assign victimSet = ctrl.selFlush ? flushSet : cpuSet;

  //////////////////////////////////////////////////
  // bus buffer and fill line
  //////////////////////////////////////////////////

  // tracks the bus every cycle, frozen from the acknowledge
  // until the read delay cycle is over
  always_ff @(posedge clk) begin
    if (!ctrl.selBusBuffer) busBuffer <= busReadLine;
  end

  // a write miss merges the CPU word into the fetched line
  always_comb begin
    fillLine = busBuffer;
    for (int i = 0; i < wordsPerLine; i++) begin
      if (cacheRW[0] && (cpuWord == wordBits'(i))) fillLine[i*32 +: 32] = cpuWriteData;
    end
  end

  //////////////////////////////////////////////////
  // way select
  //////////////////////////////////////////////////

  always_comb begin
    hitLine    = '0;
    victimLine = '0;
    for (int w = 0; w < numWays; w++) begin
      if (ctrl.hitWay[w]) hitLine = hitLine | lineMem[cpuSet][w];
      if (ctrl.victimWay[w]) victimLine = victimLine | lineMem[victimSet][w];
    end
  end

  // fresh line comes from the buffer until it is readable from the array
  assign readData = ctrl.selBusBuffer ? busBuffer[{cpuWord, 5'b0} +: 32]
                                      : hitLine[{cpuWord, 5'b0} +: 32];

  //////////////////////////////////////////////////
  // line storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int w = 0; w < numWays; w++) begin
      if (ctrl.setValid && ctrl.victimWay[w]) begin
        lineMem[cpuSet][w] <= fillLine;
      end else if (ctrl.setDirty && ctrl.hitWay[w]) begin
        // write hit, single word
        lineMem[cpuSet][w][{cpuWord, 5'b0} +: 32] <= cpuWriteData;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/cacheTagArray.sv */
// cache tag array
`default_nettype none

module cacheTagArray
  import cachePkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  cacheAdrT           cpuAdr,
  input  cacheRwT            cacheRW,
  cacheCtrlIf.tags           ctrl,
  output logic [setBits-1:0] flushSet
);

  logic [numSets-1:0][numWays-1:0] validBits;
  logic [numSets-1:0][numWays-1:0] dirtyBits;
  logic [tagBits-1:0]              tagMem [numSets][numWays];
  logic [numSets-1:0]              lruBits;   // index of the least recently used way
  logic                            flushWay;
  logic [setBits-1:0]              cpuSet;
  logic [setBits-1:0]              actSet;
  logic [numWays-1:0]              wayMatch;
  logic [numWays-1:0]              updWay;

  assign cpuSet = cpuAdr.lookup.set;
  // flush walks its own set, everything else follows the CPU
  assign actSet = ctrl.selFlush ? flushSet : cpuSet;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  // both ways compared in parallel
  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      wayMatch[w] = validBits[cpuSet][w] && (tagMem[cpuSet][w] == cpuAdr.lookup.tag);
    end
  end

  // no request, no hit
  assign ctrl.hitWay   = (cacheRW != 2'b00) ? wayMatch : '0;
  assign ctrl.cacheHit = |ctrl.hitWay;

  // first invalid way, way 0 first, else the LRU way
  always_comb begin
    if (ctrl.selFlush) begin
      ctrl.victimWay = numWays'(1) << flushWay;
    end else begin
      ctrl.victimWay = numWays'(1) << lruBits[cpuSet];
      for (int w = numWays - 1; w >= 0; w--) begin
        if (!validBits[cpuSet][w]) ctrl.victimWay = numWays'(1) << w;
      end
    end
  end

  always_comb begin
    ctrl.victimTag = '0;
    for (int w = 0; w < numWays; w++) begin
      if (ctrl.victimWay[w]) ctrl.victimTag = ctrl.victimTag | tagMem[actSet][w];
    end
  end

  assign ctrl.victimDirty = |(dirtyBits[actSet] & ctrl.victimWay);

  //////////////////////////////////////////////////
  // state update
  //////////////////////////////////////////////////

  // fill writes the victim way, a hit updates its own way
  assign updWay = ctrl.setValid ? ctrl.victimWay : ctrl.hitWay;

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits   <= '0;
    end else begin
      for (int w = 0; w < numWays; w++) begin
        if (ctrl.setValid && ctrl.victimWay[w]) validBits[cpuSet][w] <= 1'b1;
        if (ctrl.setDirty && updWay[w]) dirtyBits[actSet][w] <= 1'b1;
        else if (ctrl.clearDirty && ctrl.victimWay[w]) dirtyBits[actSet][w] <= 1'b0;
      end
      // the way not just used becomes LRU
      if (ctrl.lruWriteEn) lruBits[cpuSet] <= updWay[0];
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < numWays; w++) begin
      if (ctrl.setValid && ctrl.victimWay[w]) tagMem[cpuSet][w] <= cpuAdr.lookup.tag;
    end
  end

  //////////////////////////////////////////////////
  // flush counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || ctrl.flushAdrCntRst) flushSet <= '0;
    else if (ctrl.flushAdrCntEn) flushSet <= flushSet + 1'b1;
    if (reset || ctrl.flushWayCntRst) flushWay <= 1'b0;
    else if (ctrl.flushWayCntEn) flushWay <= flushWay + 1'b1;
  end

  assign ctrl.flushAdrFlag = flushSet == setBits'(numSets - 1);
  assign ctrl.flushWayFlag = flushWay == 1'(numWays - 1);

endmodule

`default_nettype wire

/* hdl/cacheFsm.sv */
// cache controller FSM
`default_nettype none

module cacheFsm
  import cachePkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  cacheRwT cacheRW,
  input  logic    flushCache,
  input  logic    cpuBusy,
  input  logic    busAck,
  cacheCtrlIf.fsm ctrl,
  output logic    cacheStall,
  output logic    cacheCommitted,
  output logic    cacheAccess,
  output logic    cacheMiss,
  output cacheRwT busRW
);

  logic [3:0] state;
  logic [3:0] nextState;
  logic       anyReq;
  logic       anyMiss;
  logic       anyHit;
  logic       anyUpdateHit;
  logic       flushFlag;
  logic       wayNotAdr;

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  assign anyReq       = cacheRW[1] | cacheRW[0];
  // a flush request takes priority over a miss
  assign anyMiss      = anyReq & ~ctrl.cacheHit & ~flushCache;
  assign anyUpdateHit = cacheRW[0] & ctrl.cacheHit;
  assign anyHit       = anyReq & ctrl.cacheHit;
  // last set and last way reached
  assign flushFlag    = ctrl.flushAdrFlag & ctrl.flushWayFlag;
  assign wayNotAdr    = ctrl.flushWayFlag & ~ctrl.flushAdrFlag;

  // performance counter pulses, only counted in ready
  assign cacheAccess = anyReq & (state == stReady);
  assign cacheMiss   = cacheAccess & ~ctrl.cacheHit;

  //////////////////////////////////////////////////
  // state register and next state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = stReady;
    case (state)
      stReady: begin
        if (flushCache) nextState = stFlushStart;
        // dirty victim goes out before the fetch
        else if (anyMiss && ctrl.victimDirty) nextState = stMissEvict;
        else if (anyMiss) nextState = stMissFetch;
        else nextState = stReady;
      end
      stMissFetch: nextState = busAck ? stMissWriteLine : stMissFetch;
      stMissEvict: nextState = busAck ? stMissFetch : stMissEvict;
      // a write finishes with the fill, a read still needs its delay cycle
      stMissWriteLine: nextState = cacheRW[0] ? stReady : stMissReadDelay;
      stMissReadDelay: nextState = cpuBusy ? stMissReadDelay : stReady;
      stFlushStart: nextState = stFlushCheck;
      stFlushCheck: begin
        if (ctrl.victimDirty) nextState = stFlushWriteBack;
        else if (flushFlag) nextState = stReady;
        else if (ctrl.flushWayFlag) nextState = stFlushIncr;
        else nextState = stFlushCheck;
      end
      stFlushIncr: nextState = stFlushCheck;
      stFlushWriteBack: begin
        if (!busAck) nextState = stFlushWriteBack;
        else if (flushFlag) nextState = stReady;
        else if (ctrl.flushWayFlag) nextState = stFlushIncr;
        else nextState = stFlushCheck;
      end
      default: nextState = stReady;
    endcase
  end

  //////////////////////////////////////////////////
  // CPU side
  //////////////////////////////////////////////////

  assign cacheCommitted = state != stReady;

  // stall drops in the last cycle of each sequence
  assign cacheStall = (state == stReady && (flushCache || anyMiss)) ||
                      (state == stMissFetch) ||
                      (state == stMissEvict) ||
                      (state == stMissWriteLine && !cacheRW[0]) ||
                      (state == stFlushStart) ||
                      (state == stFlushCheck && (ctrl.victimDirty || !flushFlag)) ||
                      (state == stFlushIncr) ||
                      (state == stFlushWriteBack && !(busAck && flushFlag));

  //////////////////////////////////////////////////
  // array strobes
  //////////////////////////////////////////////////

  assign ctrl.setValid   = state == stMissWriteLine;
  assign ctrl.setDirty   = (state == stReady && anyUpdateHit) ||
                           (state == stMissWriteLine && cacheRW[0]);
  assign ctrl.clearDirty = (state == stMissWriteLine && !cacheRW[0]) ||
                           (state == stFlushWriteBack && busAck);
  assign ctrl.lruWriteEn = (state == stReady && anyHit) || (state == stMissWriteLine);

  // victim address on the bus while a write-back is pending
  assign ctrl.selEvict = (state == stMissEvict && !busAck) ||
                         (state == stReady && anyMiss && ctrl.victimDirty);
  assign ctrl.selFlush = (state == stFlushStart) || (state == stFlushCheck) ||
                         (state == stFlushIncr) || (state == stFlushWriteBack);
  assign ctrl.selBusBuffer = (state == stMissWriteLine) || (state == stMissReadDelay);

  // flush walk, way first then set
  assign ctrl.flushAdrCntEn  = (state == stFlushCheck && !ctrl.victimDirty && wayNotAdr) ||
                               (state == stFlushWriteBack && busAck && wayNotAdr);
  assign ctrl.flushWayCntEn  = (state == stFlushCheck && !ctrl.victimDirty && !flushFlag) ||
                               (state == stFlushWriteBack && busAck && !flushFlag);
  assign ctrl.flushAdrCntRst = state == stReady;
  assign ctrl.flushWayCntRst = (state == stReady) || (state == stFlushIncr);

  //////////////////////////////////////////////////
  // bus request level
  //////////////////////////////////////////////////

  // read switches on in the acknowledge cycle of an eviction
  assign busRW[1] = (state == stReady && anyMiss && !ctrl.victimDirty) ||
                    (state == stMissFetch && !busAck) ||
                    (state == stMissEvict && busAck);
  assign busRW[0] = (state == stReady && anyMiss && ctrl.victimDirty) ||
                    (state == stMissEvict && !busAck) ||
                    (state == stFlushCheck && ctrl.victimDirty) ||
                    (state == stFlushWriteBack && !busAck);

endmodule

`default_nettype wire

/* hdl/cacheCtrlIf.sv */
// cache control interface
`default_nettype none

interface cacheCtrlIf import cachePkg::*; ();

  // strobes from the controller
  logic setValid;
  logic setDirty;
  logic clearDirty;
  logic lruWriteEn;
  logic selEvict;
  logic selFlush;
  logic selBusBuffer;
  logic flushAdrCntEn;
  logic flushWayCntEn;
  logic flushAdrCntRst;
  logic flushWayCntRst;

  // lookup results from the tag array
  logic               cacheHit;
  logic               victimDirty;
  logic               flushAdrFlag;
  logic               flushWayFlag;
  logic [numWays-1:0] hitWay;     // one-hot
  logic [numWays-1:0] victimWay;  // one-hot, flush way while flushing
  logic [tagBits-1:0] victimTag;

  modport fsm (
    output setValid, setDirty, clearDirty, lruWriteEn, selEvict, selFlush, selBusBuffer,
           flushAdrCntEn, flushWayCntEn, flushAdrCntRst, flushWayCntRst,
    input  cacheHit, victimDirty, flushAdrFlag, flushWayFlag
  );

  modport tags (
    input  setValid, setDirty, clearDirty, lruWriteEn, selFlush,
           flushAdrCntEn, flushWayCntEn, flushAdrCntRst, flushWayCntRst,
    output cacheHit, victimDirty, flushAdrFlag, flushWayFlag, hitWay, victimWay, victimTag
  );

  // data side also needs selFlush to pick the flush set for the victim line
  modport data (
    input setValid, setDirty, selFlush, selBusBuffer, hitWay, victimWay
  );

endinterface

`default_nettype wire

/* hdl/cachePkg.sv */
// data cache shared definitions
`default_nettype none

package cachePkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int numWays      = 2;
  localparam int numSets      = 8;
  localparam int setBits      = 3;
  localparam int wordsPerLine = 4;
  localparam int wordBits     = 2;
  localparam int tagBits      = 27;
  localparam int lineBits     = 128;

  // controller state codes
  localparam logic [3:0] stReady          = 4'd0;
  localparam logic [3:0] stMissFetch      = 4'd1;
  localparam logic [3:0] stMissEvict      = 4'd2;
  localparam logic [3:0] stMissWriteLine  = 4'd3;
  localparam logic [3:0] stMissReadDelay  = 4'd4;
  localparam logic [3:0] stFlushStart     = 4'd5;
  localparam logic [3:0] stFlushCheck     = 4'd6;
  localparam logic [3:0] stFlushIncr      = 4'd7;
  localparam logic [3:0] stFlushWriteBack = 4'd8;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // bit 1 read, bit 0 write, zero when idle
  typedef logic [1:0] cacheRwT;

  // one word address, seen by lookup or by the bus
  typedef union packed {
    struct packed {
      logic [tagBits-1:0]  tag;
      logic [setBits-1:0]  set;
      logic [wordBits-1:0] word;
    } lookup;
    struct packed {
      logic [tagBits+setBits-1:0] line;
      logic [wordBits-1:0]        word;
    } bus;
  } cacheAdrT;

endpackage

`default_nettype wire
